// File: test/prd_cases.txt
// stage code, start delay, done delay, lane 0 write count, new_cal_done count
// all values hex, one request per line, ff ends the list
01 00 00 06 02
02 00 00 00 00
01 03 05 06 02
04 00 00 00 00
01 01 00 06 02
01 00 07 06 02
02 05 05 00 00
01 0a 02 06 02
04 02 01 00 00
01 02 0c 06 02
01 06 06 06 02
ff 00 00 00 00

// File: list.f
verilog/bank_pkg.sv
verilog/prd_sched_pkg.sv
verilog/prd_stage_ctrl.sv
verilog/prd_cmd_decode.sv
verilog/skew_line.sv
verilog/pe_config_top.sv
test/tb_pe_config.sv

// File: test/tb_pe_config.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pe_config
  import bank_pkg::*;
  import prd_sched_pkg::*;
();

  localparam int wait_limit = 64;
  localparam int max_cases  = 32;
  localparam int ph2_first  = 18;
  localparam int last_step  = 35;
  localparam int sel_start  = 0;
  localparam int sel_done   = 1;

  logic        clk          = 1'b0;
  logic        sys_rst      = 1'b1;
  stage_code_t stage_val    = stage_idle;
  logic        nl_start_val = 1'b0;
  logic        nl_done_rdy  = 1'b0;
  logic        stage_rdy;
  logic        nl_start_rdy;
  logic        nl_done_val;
  bank_cmd_t   bank_a [lanes_c];
  bank_cmd_t   bank_b [lanes_c];
  pe_sel_t     pe_sel_lanes [lanes_c];
  pe_en_t      pe_en;
  logic        new_cal_en;
  logic        new_cal_done;

  logic [7:0] case_mem [0:5*max_cases-1];
  integer     seed;
  int         err_count    = 0;
  int         tests_run    = 0;
  int         tests_failed = 0;
  bit         aborted      = 1'b0;
  int         wr_cnt;
  int         done_cnt;
  int         en_cnt;

  pe_config_top #(
    .LANES (lanes_c)
  ) UUT (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .stage_val    (stage_val),
    .stage_rdy    (stage_rdy),
    .nl_start_val (nl_start_val),
    .nl_start_rdy (nl_start_rdy),
    .nl_done_rdy  (nl_done_rdy),
    .nl_done_val  (nl_done_val),
    .bank_a       (bank_a),
    .bank_b       (bank_b),
    .pe_sel_lanes (pe_sel_lanes),
    .pe_en        (pe_en),
    .new_cal_en   (new_cal_en),
    .new_cal_done (new_cal_done)
  );

  always #20 clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  // step inside the current phase or -1 outside the sequence
  function automatic int step_of(input int c);
    if (c < 0 || c > last_step) return -1;
    return (c >= ph2_first) ? c - ph2_first : c;
  endfunction

  function automatic bank_cmd_t mk_cmd(input int addr, input bit we, input bit dsel);
    bank_cmd_t cmd;
    cmd          = '0;
    cmd.en       = 1'b1;
    cmd.we       = we;
    cmd.addr     = bank_aw_c'(addr);
    cmd.dout_sel = dsel;
    return cmd;
  endfunction

  // expected decoder port A command for count c
  function automatic bank_cmd_t sched_a(input int c);
    int r;
    r = step_of(c);
    if (r < 0) return '0;
    if (c < ph2_first) begin
      if (r < 3) return mk_cmd(f_xi_off + r, 1'b0, 1'b0);
    end else begin
      if (r < 3) return mk_cmd(f_cov_off + r, 1'b0, 1'b0);
      if (r == 4 || r == 6 || r == 8) return mk_cmd(m_t_off + (r - 4) / 2, 1'b0, 1'b1);
    end
    return '0;
  endfunction

  function automatic bank_cmd_t sched_b(input int c);
    int r;
    r = step_of(c);
    if (r < 0) return '0;
    if (c < ph2_first) begin
      if (r < 3) return mk_cmd(t_cov_off + r, 1'b0, 1'b0);
      if (r == 10 || r == 12 || r == 14) return mk_cmd(f_cov_off + (r - 10) / 2, 1'b1, 1'b0);
    end else begin
      if (r < 3) return mk_cmd(f_xi_off + r, 1'b0, 1'b0);
      if (r == 10 || r == 12 || r == 14) return mk_cmd(t_cov_off + (r - 10) / 2, 1'b1, 1'b0);
    end
    return '0;
  endfunction

  function automatic pe_sel_t sched_sel(input int c);
    pe_sel_t s;
    s = '0;
    if (c >= ph2_first && c <= last_step) s.m_sel = 2'd1;
    return s;
  endfunction

  function automatic pe_en_t sched_en(input int c);
    pe_en_t e;
    e = '0;
    if (step_of(c) >= 0) begin
      e.a = 4'b0111;
      e.b = 4'b0111;
      e.c = 4'b0111;
      if (c >= ph2_first) e.m = 4'b0111;
    end
    return e;
  endfunction

  function automatic bit cal_en_at(input int c);
    return (step_of(c) >= 4 && step_of(c) <= 6);
  endfunction

  function automatic bit cal_done_at(input int c);
    return (step_of(c) == 7);
  endfunction

  function automatic bit outputs_quiet();
    bit q;
    q = (pe_en === '0) && (new_cal_en === 1'b0) && (new_cal_done === 1'b0);
    for (int k = 0; k < lanes_c; k++) begin
      if (bank_a[k] !== '0 || bank_b[k] !== '0 || pe_sel_lanes[k] !== '0) q = 1'b0;
    end
    return q;
  endfunction

  function automatic logic watched(input int which);
    case (which)
      sel_start: return nl_start_rdy;
      sel_done:  return nl_done_val;
      default:   return stage_rdy;
    endcase
  endfunction

  task automatic wait_high(input int which, input string what, output int waited);
    waited = 0;
    @(negedge clk);
    while (watched(which) !== 1'b1) begin
      if (waited == wait_limit) begin
        $display("timeout: %s not seen within %0d cycles", what, wait_limit);
        aborted = 1'b1;
        return;
      end
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic tally();
    if (bank_b[0].en === 1'b1 && bank_b[0].we === 1'b1) wr_cnt++;
    if (new_cal_done === 1'b1) done_cnt++;
    if (new_cal_en === 1'b1) en_cnt++;
  endtask

  task automatic watch_ignored();
    repeat (20) begin
      @(negedge clk);
      if (stage_rdy !== 1'b1 || nl_start_rdy !== 1'b0 || nl_done_val !== 1'b0)
        report_mismatch($sformatf("ignored code: stage_rdy %b nl_start_rdy %b nl_done_val %b",
                                  stage_rdy, nl_start_rdy, nl_done_val));
      if (!outputs_quiet()) report_mismatch("command or pulse after an ignored code");
      tally();
    end
  endtask

  task automatic prd_handshake(input int sdly, input int ddly);
    int waited;
    wait_high(sel_start, "nl_start_rdy after the request", waited);
    if (aborted) return;
    if (waited != 0 || stage_rdy !== 1'b0)
      report_mismatch($sformatf("accept: nl_start_rdy after %0d cycles, stage_rdy %b",
                                waited, stage_rdy));
    // start side held back by the nonlinear unit
    repeat (sdly) begin
      @(negedge clk);
      if (nl_start_rdy !== 1'b1 || nl_done_val !== 1'b0 || stage_rdy !== 1'b0 ||
          !outputs_quiet())
        report_mismatch("state moved while the start transfer was held back");
    end
    @(posedge clk);
    nl_start_val <= 1'b1;
    wait_high(sel_start, "start transfer", waited);
    if (aborted) return;
    @(posedge clk);
    nl_start_val <= 1'b0;
    wait_high(sel_done, "nl_done_val after the start transfer", waited);
    if (aborted) return;
    if (waited != 0 || nl_start_rdy !== 1'b0)
      report_mismatch($sformatf("nl_done_val after %0d cycles, nl_start_rdy %b",
                                waited, nl_start_rdy));
    repeat (ddly) begin
      @(negedge clk);
      if (nl_done_val !== 1'b1 || stage_rdy !== 1'b0 || !outputs_quiet())
        report_mismatch("state moved while the done transfer was held back");
    end
    @(posedge clk);
    nl_done_rdy <= 1'b1;
    wait_high(sel_done, "done transfer", waited);
    if (aborted) return;
    @(posedge clk);
    nl_done_rdy <= 1'b0;
  endtask

  // cycle n counts from the first cycle after the done transfer
  task automatic check_window();
    bank_cmd_t hist_a [0:47];
    bank_cmd_t hist_b [0:47];
    pe_sel_t   hist_s [0:47];
    for (int i = 0; i < 4; i++) begin
      hist_a[i] = '0;
      hist_b[i] = '0;
      hist_s[i] = '0;
    end
    for (int n = 0; n < 40; n++) begin
      @(negedge clk);
      if (stage_rdy !== (n >= 36))
        report_mismatch($sformatf("stage_rdy %b in cycle %0d", stage_rdy, n));
      if (nl_start_rdy !== 1'b0 || nl_done_val !== 1'b0)
        report_mismatch($sformatf("nl_start_rdy %b nl_done_val %b in cycle %0d",
                                  nl_start_rdy, nl_done_val, n));
      if (bank_a[0] !== sched_a(n - 2))
        report_mismatch($sformatf("lane 0 port A cycle %0d got %h expected %h",
                                  n, bank_a[0], sched_a(n - 2)));
      if (bank_b[0] !== sched_b(n - 2))
        report_mismatch($sformatf("lane 0 port B cycle %0d got %h expected %h",
                                  n, bank_b[0], sched_b(n - 2)));
      if (pe_sel_lanes[0] !== sched_sel(n - 2))
        report_mismatch($sformatf("lane 0 select cycle %0d got %h", n, pe_sel_lanes[0]));
      if (pe_en !== sched_en(n - 1))
        report_mismatch($sformatf("pe_en cycle %0d got %h expected %h",
                                  n, pe_en, sched_en(n - 1)));
      if (new_cal_en !== cal_en_at(n - 1) || new_cal_done !== cal_done_at(n - 1))
        report_mismatch($sformatf("new_cal_en %b new_cal_done %b in cycle %0d",
                                  new_cal_en, new_cal_done, n));
      for (int k = 1; k < lanes_c; k++) begin
        if (bank_a[k] !== hist_a[n+4-k] || bank_b[k] !== hist_b[n+4-k] ||
            pe_sel_lanes[k] !== hist_s[n+4-k])
          report_mismatch($sformatf("lane %0d is not lane 0 delayed, cycle %0d", k, n));
      end
      hist_a[n+4] = bank_a[0];
      hist_b[n+4] = bank_b[0];
      hist_s[n+4] = pe_sel_lanes[0];
      tally();
    end
  endtask

  task automatic run_case(input int idx);
    stage_code_t code;
    int          exp_wr;
    int          exp_done;
    int          errs_before;
    code        = case_mem[5*idx][2:0];
    exp_wr      = int'(case_mem[5*idx+3]);
    exp_done    = int'(case_mem[5*idx+4]);
    errs_before = err_count;
    wr_cnt      = 0;
    done_cnt    = 0;
    en_cnt      = 0;
    @(posedge clk);
    stage_val <= code;
    @(posedge clk);
    stage_val <= stage_idle;
    if (code != stage_prd) begin
      watch_ignored();
    end else begin
      prd_handshake(int'(case_mem[5*idx+1]), int'(case_mem[5*idx+2]));
      if (!aborted) check_window();
    end
    if (!aborted) begin
      if (wr_cnt != exp_wr)
        report_mismatch($sformatf("lane 0 writes %0d expected %0d", wr_cnt, exp_wr));
      if (done_cnt != exp_done)
        report_mismatch($sformatf("new_cal_done pulses %0d expected %0d", done_cnt, exp_done));
      if (en_cnt != 3 * exp_done)
        report_mismatch($sformatf("new_cal_en cycles %0d expected %0d", en_cnt, 3 * exp_done));
    end
    tests_run++;
    if (err_count != errs_before || aborted) tests_failed++;
    $display("test %0d stage %b writes %0d done %0d: %s", idx, code, wr_cnt, done_cnt,
             (err_count == errs_before && !aborted) ? "ok" : "errors");
  endtask

  initial begin
    int t;
    int gap;
    seed = 27;
    $readmemh("test/prd_cases.txt", case_mem);
    repeat (5) @(posedge clk);
    sys_rst <= 1'b0;
    @(negedge clk);
    if (stage_rdy !== 1'b1 || nl_start_rdy !== 1'b0 || nl_done_val !== 1'b0 ||
        !outputs_quiet())
      report_mismatch("outputs not idle after reset");
    tests_run++;
    if (err_count != 0) tests_failed++;
    $display("reset check: %s", (err_count == 0) ? "ok" : "errors");
    t = 0;
    while (!aborted && t < max_cases && case_mem[5*t] !== 8'hff) begin
      run_case(t);
      // random idle gap between requests
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk);
      t++;
    end
    $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_count);
    if (aborted || err_count != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/pe_config_top.sv
`timescale 1ns/100ps
`default_nettype none

module pe_config_top
  import bank_pkg::*;
  import prd_sched_pkg::*;
#(
  parameter int LANES = lanes_c
) (
  input  logic        clk,
  input  logic        sys_rst,
  input  stage_code_t stage_val,
  output logic        stage_rdy,
  input  logic        nl_start_val,
  output logic        nl_start_rdy,
  input  logic        nl_done_rdy,
  output logic        nl_done_val,
  output bank_cmd_t   bank_a [LANES],
  output bank_cmd_t   bank_b [LANES],
  output pe_sel_t     pe_sel_lanes [LANES],
  output pe_en_t      pe_en,
  output logic        new_cal_en,
  output logic        new_cal_done
);

  prd_phase_t phase;
  cnt_t       cnt;
  bank_cmd_t  port_a_cmd;
  bank_cmd_t  port_b_cmd;
  pe_sel_t    pe_sel;

  prd_stage_ctrl u_ctrl (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .stage_val    (stage_val),
    .stage_rdy    (stage_rdy),
    .nl_start_val (nl_start_val),
    .nl_start_rdy (nl_start_rdy),
    .nl_done_rdy  (nl_done_rdy),
    .nl_done_val  (nl_done_val),
    .phase        (phase),
    .cnt          (cnt)
  );

  prd_cmd_decode u_decode (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .phase        (phase),
    .cnt          (cnt),
    .port_a_cmd   (port_a_cmd),
    .port_b_cmd   (port_b_cmd),
    .pe_sel       (pe_sel),
    .pe_en        (pe_en),
    .new_cal_en   (new_cal_en),
    .new_cal_done (new_cal_done)
  );

  // systolic stagger of both bank ports and the array selects
  skew_line #(
    .payload_t (bank_cmd_t),
    .LANES     (LANES)
  ) u_skew_a (
    .clk  (clk),
    .din  (port_a_cmd),
    .dout (bank_a)
  );

  skew_line #(
    .payload_t (bank_cmd_t),
    .LANES     (LANES)
  ) u_skew_b (
    .clk  (clk),
    .din  (port_b_cmd),
    .dout (bank_b)
  );

  skew_line #(
    .payload_t (pe_sel_t),
    .LANES     (LANES)
  ) u_skew_sel (
    .clk  (clk),
    .din  (pe_sel),
    .dout (pe_sel_lanes)
  );

endmodule

`default_nettype wire

// File: verilog/skew_line.sv
`timescale 1ns/100ps
`default_nettype none

module skew_line #(
  parameter type payload_t = logic [15:0],
  parameter int  LANES     = 4
) (
  input  logic     clk,
  input  payload_t din,
  output payload_t dout [LANES]
);

  // each lane sits one stage behind the previous one
  always_ff @(posedge clk) begin
    dout[0] <= din;
    for (int k = 1; k < LANES; k++) begin
      dout[k] <= dout[k-1];
    end
  end

endmodule

`default_nettype wire

// File: verilog/prd_cmd_decode.sv
`timescale 1ns/100ps
`default_nettype none

module prd_cmd_decode
  import bank_pkg::*;
  import prd_sched_pkg::*;
(
  input  logic       clk,
  input  logic       sys_rst,
  input  prd_phase_t phase,
  input  cnt_t       cnt,
  output bank_cmd_t  port_a_cmd,
  output bank_cmd_t  port_b_cmd,
  output pe_sel_t    pe_sel,
  output pe_en_t     pe_en,
  output logic       new_cal_en,
  output logic       new_cal_done
);

  // lanes covered by one 3x3 block
  localparam logic [lanes_c-1:0] blk_mask = lanes_c'((1 << block_n) - 1);

  cnt_t      r;
  cnt_t      wb_idx;
  cnt_t      m_idx;
  logic      wb_hit;
  logic      m_hit;
  logic      feed;
  bank_cmd_t a_nxt;
  bank_cmd_t b_nxt;
  pe_sel_t   sel_nxt;
  pe_en_t    en_nxt;
  logic      cal_en_nxt;
  logic      cal_done_nxt;

  function automatic bank_cmd_t rd_cmd(input logic [bank_aw_c-1:0] addr, input logic dsel);
    bank_cmd_t cmd;
    cmd          = '0;
    cmd.en       = 1'b1;
    cmd.addr     = addr;
    cmd.dout_sel = dsel;
    return cmd;
  endfunction

  function automatic bank_cmd_t wr_cmd(input logic [bank_aw_c-1:0] addr);
    bank_cmd_t cmd;
    cmd      = '0;
    cmd.en   = 1'b1;
    cmd.we   = 1'b1;
    cmd.addr = addr;
    return cmd;
  endfunction

  // phase 2 steps count from its own start
  assign r    = (phase == ph_2) ? cnt - phase_2_start : cnt;
  assign feed = (r < block_n);

  // write-back and noise slots, one per block row
  always_comb begin
    wb_hit = 1'b0;
    wb_idx = '0;
    m_hit  = 1'b0;
    m_idx  = '0;
    for (int i = 0; i < block_n; i++) begin
      if (r == wb_first + wb_stride * cnt_t'(i)) begin
        wb_hit = 1'b1;
        wb_idx = cnt_t'(i);
      end
      if (r == m_first + m_stride * cnt_t'(i)) begin
        m_hit = 1'b1;
        m_idx = cnt_t'(i);
      end
    end
  end

  always_comb begin
    a_nxt        = '0;
    b_nxt        = '0;
    sel_nxt      = '0;
    en_nxt       = '0;
    cal_en_nxt   = 1'b0;
    cal_done_nxt = 1'b0;
    case (phase)
      ph_1: begin
        // jacobian times covariance into f_cov
        en_nxt.a = blk_mask;
        en_nxt.b = blk_mask;
        en_nxt.c = blk_mask;
        if (feed) begin
          a_nxt = rd_cmd(f_xi_off + r, 1'b0);
          b_nxt = rd_cmd(t_cov_off + r, 1'b0);
        end else if (wb_hit) begin
          b_nxt = wr_cmd(f_cov_off + wb_idx);
        end
      end
      ph_2: begin
        // f_cov times covariance plus noise back into t_cov
        en_nxt.a      = blk_mask;
        en_nxt.b      = blk_mask;
        en_nxt.m      = blk_mask;
        en_nxt.c      = blk_mask;
        sel_nxt.m_sel = 2'b01;
        if (feed) begin
          a_nxt = rd_cmd(f_cov_off + r, 1'b0);
          b_nxt = rd_cmd(f_xi_off + r, 1'b0);
        end else if (m_hit) begin
          // noise rows leave on the port A alternate output
          a_nxt = rd_cmd(m_t_off + m_idx, 1'b1);
        end
        if (wb_hit) begin
          b_nxt = wr_cmd(t_cov_off + wb_idx);
        end
      end
      default: begin
        a_nxt = '0;
      end
    endcase
    if (phase == ph_1 || phase == ph_2) begin
      cal_en_nxt   = (r >= feed_delay) && (r < feed_delay + block_n);
      cal_done_nxt = (r == feed_delay + block_n);
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      port_a_cmd   <= '0;
      port_b_cmd   <= '0;
      pe_sel       <= '0;
      pe_en        <= '0;
      new_cal_en   <= 1'b0;
      new_cal_done <= 1'b0;
    end else begin
      port_a_cmd   <= a_nxt;
      port_b_cmd   <= b_nxt;
      pe_sel       <= sel_nxt;
      pe_en        <= en_nxt;
      new_cal_en   <= cal_en_nxt;
      new_cal_done <= cal_done_nxt;
    end
  end

endmodule

`default_nettype wire

// File: verilog/prd_stage_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module prd_stage_ctrl
  import prd_sched_pkg::*;
(
  input  logic        clk,
  input  logic        sys_rst,
  input  stage_code_t stage_val,
  output logic        stage_rdy,
  input  logic        nl_start_val,
  output logic        nl_start_rdy,
  input  logic        nl_done_rdy,
  output logic        nl_done_val,
  output prd_phase_t  phase,
  output cnt_t        cnt
);

  stage_code_t stage_q;
  logic        start_xfer;
  logic        done_xfer;

  // requests are only taken while no stage is running
  assign stage_rdy = (stage_q == stage_idle);

  // prediction accepted, waiting for the nonlinear unit to start
  assign nl_start_rdy = (stage_q == stage_prd) && (phase == ph_idle);
  assign nl_done_val  = (phase == ph_nonlinear);

  assign start_xfer = nl_start_rdy && nl_start_val;
  assign done_xfer  = nl_done_val && nl_done_rdy;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      stage_q <= stage_idle;
      phase   <= ph_idle;
      cnt     <= '0;
    end else begin
      case (phase)
        ph_idle: begin
          // new and update codes complete the transfer and are dropped
          if (stage_rdy && stage_val == stage_prd) begin
            stage_q <= stage_prd;
          end else if (start_xfer) begin
            phase <= ph_nonlinear;
          end
        end
        ph_nonlinear: begin
          if (done_xfer) begin
            phase <= ph_1;
            cnt   <= '0;
          end
        end
        ph_1: begin
          if (cnt == phase_2_start - 12'd1) begin
            phase <= ph_2;
          end
          cnt <= cnt + 12'd1;
        end
        ph_2: begin
          // last step of phase 2 hands the stage back
          if (cnt == seq_end) begin
            phase   <= ph_idle;
            stage_q <= stage_idle;
            cnt     <= '0;
          end else begin
            cnt <= cnt + 12'd1;
          end
        end
        default: begin
          phase <= ph_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/prd_sched_pkg.sv
`default_nettype none

package prd_sched_pkg;

  // one-hot stage request codes
  typedef logic [2:0] stage_code_t;

  localparam stage_code_t stage_idle = 3'b000;
  localparam stage_code_t stage_prd  = 3'b001;
  localparam stage_code_t stage_new  = 3'b010;
  localparam stage_code_t stage_upd  = 3'b100;

  typedef enum logic [1:0] {
    ph_idle,
    ph_nonlinear,
    ph_1,
    ph_2
  } prd_phase_t;

  typedef logic [11:0] cnt_t;

  // step counts of the prediction sequence
  localparam cnt_t phase_2_start = 12'd18;
  localparam cnt_t seq_end       = 12'd35;
  localparam cnt_t block_n       = 12'd3;

  // issue to array input latency
  localparam cnt_t feed_delay = 12'd4;

  // result write-back and noise read slots
  localparam cnt_t wb_first  = 12'd10;
  localparam cnt_t wb_stride = 12'd2;
  localparam cnt_t m_first   = 12'd4;
  localparam cnt_t m_stride  = 12'd2;

endpackage

`default_nettype wire

// File: verilog/bank_pkg.sv
`default_nettype none

package bank_pkg;

  // systolic array width and temp bank depth
  localparam int lanes_c   = 4;
  localparam int bank_aw_c = 12;

  // temp bank layout for the prediction stage, three rows per block
  localparam logic [bank_aw_c-1:0] f_xi_off   = 12'd0;
  localparam logic [bank_aw_c-1:0] f_xi_t_off = 12'd3;
  localparam logic [bank_aw_c-1:0] t_cov_off  = 12'd6;
  localparam logic [bank_aw_c-1:0] f_cov_off  = 12'd9;
  localparam logic [bank_aw_c-1:0] m_t_off    = 12'd12;

  // one temp bank port command
  typedef struct packed {
    logic                 en;
    logic                 we;
    logic [bank_aw_c-1:0] addr;
    logic                 din_sel;
    logic                 dout_sel;
  } bank_cmd_t;

  // array input and output source selects
  typedef struct packed {
    logic       a_sel;
    logic [1:0] b_sel;
    logic [1:0] m_sel;
    logic [1:0] c_sel;
  } pe_sel_t;

  // per lane enables of the array ports
  typedef struct packed {
    logic [lanes_c-1:0] a;
    logic [lanes_c-1:0] b;
    logic [lanes_c-1:0] m;
    logic [lanes_c-1:0] c;
  } pe_en_t;

endpackage

`default_nettype wire
